// File: include/stream_cfg.svh
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// word width on both stream links
`define STREAM_DATA_WIDTH 32

// idle cycles between a request and the first word
`define STREAM_START_COUNT 32

// longest packet the length ports can describe
`define STREAM_MAX_WORDS 16

// entries in the elastic buffer
`define STREAM_FIFO_DEPTH 4

// width of the source start-up counter
`define STREAM_START_CNT_WIDTH ($clog2(`STREAM_START_COUNT + 1))

`endif

// File: logic/stream_fifo.sv
`timescale 1ns/1ps

`include "stream_cfg.svh"

module stream_fifo #(
  parameter int DEPTH = `STREAM_FIFO_DEPTH,
  parameter int WIDTH = `STREAM_DATA_WIDTH
) (
  input  logic             M_AXIS_ACLK,
  input  logic             M_AXIS_ARESETN,
  input  logic             in_tvalid,
  input  logic [WIDTH-1:0] in_tdata,
  input  logic             in_tlast,
  output logic             in_tready,
  output logic             out_tvalid,
  output logic [WIDTH-1:0] out_tdata,
  output logic             out_tlast,
  input  logic             out_tready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry is {last, data}
  logic [WIDTH:0]   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full       = (count == CNT_W'(DEPTH));
  assign out_tvalid = (count != '0);
  // a full buffer still takes a word when one leaves in the same cycle
  assign in_tready  = !full || out_tready;

  assign wr_en = in_tvalid && in_tready;
  assign rd_en = out_tvalid && out_tready;

  assign out_tdata = mem[rd_ptr][WIDTH-1:0];
  assign out_tlast = mem[rd_ptr][WIDTH];

  always_ff @(posedge M_AXIS_ACLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= {in_tlast, in_tdata};
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/stream_pkg.sv
`include "stream_cfg.svh"

package stream_pkg;

  // source sequencing
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    INIT_COUNTER = 2'd1,
    SEND_STREAM  = 2'd2,
    WAIT_RELEASE = 2'd3
  } source_state_e;

  // outcome of the most recent finished packet
  typedef enum logic [1:0] {
    // nothing finished since reset
    CHK_NONE = 2'd0,
    CHK_OK   = 2'd1,
    // sequence or framing mismatch somewhere in the packet
    CHK_DATA = 2'd2
  } check_status_e;

  // next word value after a transfer
  function automatic logic [`STREAM_DATA_WIDTH-1:0] next_word(
    input logic [`STREAM_DATA_WIDTH-1:0] word
  );
    logic [`STREAM_DATA_WIDTH-1:0] nxt;
    nxt = word + 1'b1;
    return nxt;
  endfunction

endpackage

// File: logic/stream_source.sv
`timescale 1ns/1ps

`include "stream_cfg.svh"

module stream_source (
  input  logic                          M_AXIS_ACLK,
  input  logic                          M_AXIS_ARESETN,
  input  logic                          start_req,
  input  logic [4:0]                    pkt_len,
  output logic                          start_ack,
  output logic                          m_tvalid,
  output logic [`STREAM_DATA_WIDTH-1:0] m_tdata,
  output logic                          m_tlast,
  input  logic                          m_tready
);

  localparam int CNT_W = `STREAM_START_CNT_WIDTH;

  stream_pkg::source_state_e state;

  logic [CNT_W-1:0] start_cnt;
  // index of the word currently on the link
  logic [4:0]       word_ptr;
  logic [4:0]       len_q;
  logic             tx_en;
  logic             init_done;

  assign tx_en     = m_tvalid && m_tready;
  assign init_done = (start_cnt == CNT_W'(`STREAM_START_COUNT - 1));

  // control path
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state     <= stream_pkg::IDLE;
      start_cnt <= '0;
      word_ptr  <= '0;
      start_ack <= 1'b0;
      m_tvalid  <= 1'b0;
      m_tlast   <= 1'b0;
    end else begin
      case (state)
        stream_pkg::IDLE: begin
          start_cnt <= '0;
          if (start_req) begin
            state <= stream_pkg::INIT_COUNTER;
          end
        end

        stream_pkg::INIT_COUNTER: begin
          if (init_done) begin
            if (len_q == 5'd0) begin
              // empty packet goes straight to the ack
              state     <= stream_pkg::WAIT_RELEASE;
              start_ack <= 1'b1;
            end else begin
              state    <= stream_pkg::SEND_STREAM;
              word_ptr <= 5'd1;
              m_tvalid <= 1'b1;
              m_tlast  <= (len_q == 5'd1);
            end
          end else begin
            start_cnt <= start_cnt + 1'b1;
          end
        end

        stream_pkg::SEND_STREAM: begin
          if (tx_en) begin
            if (m_tlast) begin
              m_tvalid  <= 1'b0;
              m_tlast   <= 1'b0;
              start_ack <= 1'b1;
              state     <= stream_pkg::WAIT_RELEASE;
            end else begin
              word_ptr <= word_ptr + 1'b1;
              m_tlast  <= (word_ptr + 5'd1 == len_q);
            end
          end
        end

        stream_pkg::WAIT_RELEASE: begin
          // hold ack until the request is withdrawn
          if (!start_req) begin
            start_ack <= 1'b0;
            state     <= stream_pkg::IDLE;
          end
        end

        default: begin
          state <= stream_pkg::IDLE;
        end
      endcase
    end
  end

  // payload moves only when the link is free or the word was taken
  always_ff @(posedge M_AXIS_ACLK) begin
    if (state == stream_pkg::IDLE && start_req) begin
      len_q <= pkt_len;
    end
    if (state == stream_pkg::INIT_COUNTER && init_done) begin
      m_tdata <= `STREAM_DATA_WIDTH'(1);
    end else if (state == stream_pkg::SEND_STREAM && tx_en && !m_tlast) begin
      m_tdata <= stream_pkg::next_word(m_tdata);
    end
  end

endmodule

// File: logic/stream_checker.sv
`timescale 1ns/1ps

`include "stream_cfg.svh"

module stream_checker (
  input  logic                          M_AXIS_ACLK,
  input  logic                          M_AXIS_ARESETN,
  input  logic                          s_tvalid,
  input  logic [`STREAM_DATA_WIDTH-1:0] s_tdata,
  input  logic                          s_tlast,
  output logic                          s_tready,
  input  logic                          sink_stall,
  output logic [15:0]                   pkt_count,
  output logic [15:0]                   err_count,
  output logic [4:0]                    last_len,
  output stream_pkg::check_status_e     last_status
);

  logic [`STREAM_DATA_WIDTH-1:0] expected;
  // words taken so far in the current packet
  logic [4:0]                    word_cnt;
  logic                          pkt_bad;
  logic                          accept;
  logic                          data_err;
  logic                          frame_err;
  logic                          word_bad;

  assign s_tready = !sink_stall;
  assign accept   = s_tvalid && s_tready;

  assign data_err  = (s_tdata != expected);
  // a word beyond the longest allowed packet means tlast went missing
  assign frame_err = (word_cnt == 5'(`STREAM_MAX_WORDS));
  assign word_bad  = data_err || frame_err;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      expected    <= `STREAM_DATA_WIDTH'(1);
      word_cnt    <= '0;
      pkt_bad     <= 1'b0;
      pkt_count   <= '0;
      err_count   <= '0;
      last_len    <= '0;
      last_status <= stream_pkg::CHK_NONE;
    end else if (accept) begin
      if (s_tlast) begin
        pkt_count <= pkt_count + 1'b1;
        last_len  <= frame_err ? word_cnt : word_cnt + 1'b1;
        if (pkt_bad || word_bad) begin
          err_count   <= err_count + 1'b1;
          last_status <= stream_pkg::CHK_DATA;
        end else begin
          last_status <= stream_pkg::CHK_OK;
        end
        // next packet starts over at 1
        expected <= `STREAM_DATA_WIDTH'(1);
        word_cnt <= '0;
        pkt_bad  <= 1'b0;
      end else begin
        expected <= stream_pkg::next_word(s_tdata);
        if (!frame_err) begin
          word_cnt <= word_cnt + 1'b1;
        end
        pkt_bad <= pkt_bad || word_bad;
      end
    end
  end

endmodule

// File: logic/stream_loop_top.sv
`timescale 1ns/1ps

`include "stream_cfg.svh"

module stream_loop_top (
  input  logic                      M_AXIS_ACLK,
  input  logic                      M_AXIS_ARESETN,
  input  logic                      start_req,
  input  logic [4:0]                pkt_len,
  output logic                      start_ack,
  input  logic                      sink_stall,
  output logic [15:0]               pkt_count,
  output logic [15:0]               err_count,
  output logic [4:0]                last_len,
  output stream_pkg::check_status_e last_status
);

  // source to fifo
  logic                          src_tvalid;
  logic [`STREAM_DATA_WIDTH-1:0] src_tdata;
  logic                          src_tlast;
  logic                          src_tready;

  // fifo to checker
  logic                          chk_tvalid;
  logic [`STREAM_DATA_WIDTH-1:0] chk_tdata;
  logic                          chk_tlast;
  logic                          chk_tready;

  stream_source stream_source_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .start_req      (start_req),
    .pkt_len        (pkt_len),
    .start_ack      (start_ack),
    .m_tvalid       (src_tvalid),
    .m_tdata        (src_tdata),
    .m_tlast        (src_tlast),
    .m_tready       (src_tready)
  );

  stream_fifo #(
    .DEPTH (`STREAM_FIFO_DEPTH),
    .WIDTH (`STREAM_DATA_WIDTH)
  ) stream_fifo_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .in_tvalid      (src_tvalid),
    .in_tdata       (src_tdata),
    .in_tlast       (src_tlast),
    .in_tready      (src_tready),
    .out_tvalid     (chk_tvalid),
    .out_tdata      (chk_tdata),
    .out_tlast      (chk_tlast),
    .out_tready     (chk_tready)
  );

  stream_checker stream_checker_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .s_tvalid       (chk_tvalid),
    .s_tdata        (chk_tdata),
    .s_tlast        (chk_tlast),
    .s_tready       (chk_tready),
    .sink_stall     (sink_stall),
    .pkt_count      (pkt_count),
    .err_count      (err_count),
    .last_len       (last_len),
    .last_status    (last_status)
  );

endmodule

// File: sim/stream_loop_tb.sv
`timescale 1ns/1ps

`include "stream_cfg.svh"

module stream_loop_tb;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                      M_AXIS_ACLK;
  logic                      M_AXIS_ARESETN;
  logic                      start_req;
  logic [4:0]                pkt_len;
  logic                      start_ack;
  logic                      sink_stall;
  logic [15:0]               pkt_count;
  logic [15:0]               err_count;
  logic [4:0]                last_len;
  stream_pkg::check_status_e last_status;

  int unsigned value_errs;
  int unsigned timeout_errs;
  logic [31:0] lcg_state;
  logic        stall_rand;
  // packets the checker should have counted so far
  logic [15:0] exp_count;

  stream_loop_top stream_loop_top_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .start_req      (start_req),
    .pkt_len        (pkt_len),
    .start_ack      (start_ack),
    .sink_stall     (sink_stall),
    .pkt_count      (pkt_count),
    .err_count      (err_count),
    .last_len       (last_len),
    .last_status    (last_status)
  );

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #4 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // random sink stall on about half the cycles
  always @(negedge M_AXIS_ACLK) begin
    if (stall_rand) begin
      sink_stall = (lcg_next() >= 32'h8000_0000);
    end
  end

  task automatic compare_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_len(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_status(input string name, input stream_pkg::check_status_e got,
                                input stream_pkg::check_status_e exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wait_ack(input logic level, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b1;
    while (start_ack !== level) begin
      @(negedge M_AXIS_ACLK);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        timeout_errs++;
        $display("timed out waiting for start_ack to go to %0b", level);
        ok = 1'b0;
        break;
      end
    end
  endtask

  task automatic wait_count(input logic [15:0] exp);
    int cycles;
    cycles = 0;
    while (pkt_count !== exp) begin
      @(negedge M_AXIS_ACLK);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        timeout_errs++;
        $display("timed out waiting for the checker to count packet %0d", exp);
        break;
      end
    end
  endtask

  // four-phase handshake with the request held hold_cycles past the ack
  task automatic send_packet(input logic [4:0] len, input int hold_cycles);
    bit ok;
    @(negedge M_AXIS_ACLK);
    pkt_len   = len;
    start_req = 1'b1;
    @(negedge M_AXIS_ACLK);
    wait_ack(1'b1, ok);
    if (ok) begin
      repeat (hold_cycles) begin
        @(negedge M_AXIS_ACLK);
        compare_flag("start_ack", start_ack, 1'b1);
      end
    end
    start_req = 1'b0;
    @(negedge M_AXIS_ACLK);
    wait_ack(1'b0, ok);
  endtask

  task automatic check_packet(input logic [4:0] len);
    if (len != 5'd0) begin
      exp_count = exp_count + 16'd1;
    end
    wait_count(exp_count);
    compare_count("pkt_count", pkt_count, exp_count);
    compare_count("err_count", err_count, 16'd0);
    if (len != 5'd0) begin
      compare_len("last_len", last_len, len);
      compare_status("last_status", last_status, stream_pkg::CHK_OK);
    end
  endtask

  task automatic test_reset_state();
    compare_flag("start_ack", start_ack, 1'b0);
    compare_count("pkt_count", pkt_count, 16'd0);
    compare_count("err_count", err_count, 16'd0);
    compare_status("last_status", last_status, stream_pkg::CHK_NONE);
    send_packet(5'd8, 0);
    check_packet(5'd8);
  endtask

  task automatic test_length_range();
    send_packet(5'd1, 0);
    check_packet(5'd1);
    send_packet(5'(`STREAM_MAX_WORDS), 0);
    check_packet(5'(`STREAM_MAX_WORDS));
  endtask

  task automatic test_back_pressure();
    logic [4:0]  lens [10];
    logic [31:0] r;
    // lengths drawn up front so the stall process owns the generator later
    for (int i = 0; i < 10; i++) begin
      r = lcg_next();
      lens[i] = 5'(r[19:16]) + 5'd1;
    end
    // stall process switched between falling edges
    @(posedge M_AXIS_ACLK);
    stall_rand = 1'b1;
    for (int i = 0; i < 10; i++) begin
      send_packet(lens[i], 0);
      check_packet(lens[i]);
    end
    @(posedge M_AXIS_ACLK);
    stall_rand = 1'b0;
    @(negedge M_AXIS_ACLK);
    sink_stall = 1'b0;
  endtask

  task automatic test_four_phase();
    send_packet(5'd4, 6);
    check_packet(5'd4);
    // request stays low, so nothing new may arrive
    repeat (`STREAM_START_COUNT + 16) @(negedge M_AXIS_ACLK);
    compare_flag("start_ack", start_ack, 1'b0);
    compare_count("pkt_count", pkt_count, exp_count);
  endtask

  task automatic test_zero_length();
    send_packet(5'd0, 0);
    repeat (8) @(negedge M_AXIS_ACLK);
    compare_count("pkt_count", pkt_count, exp_count);
    compare_count("err_count", err_count, 16'd0);
  endtask

  task automatic test_mid_packet_reset();
    @(negedge M_AXIS_ACLK);
    sink_stall = 1'b1;
    pkt_len    = 5'd16;
    start_req  = 1'b1;
    // long enough for the fifo to fill and the source to stall
    repeat (`STREAM_START_COUNT + 12) @(negedge M_AXIS_ACLK);
    compare_flag("start_ack", start_ack, 1'b0);
    M_AXIS_ARESETN = 1'b0;
    start_req      = 1'b0;
    repeat (2) @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;
    compare_flag("start_ack", start_ack, 1'b0);
    compare_count("pkt_count", pkt_count, 16'd0);
    compare_count("err_count", err_count, 16'd0);
    compare_status("last_status", last_status, stream_pkg::CHK_NONE);
    exp_count  = 16'd0;
    sink_stall = 1'b0;
    send_packet(5'd5, 0);
    check_packet(5'd5);
  endtask

  initial begin
    value_errs     = 0;
    timeout_errs   = 0;
    lcg_state      = 32'd82521;
    stall_rand     = 1'b0;
    exp_count      = 16'd0;
    M_AXIS_ARESETN = 1'b0;
    start_req      = 1'b0;
    pkt_len        = 5'd0;
    sink_stall     = 1'b0;
    repeat (2) @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;

    test_reset_state();
    test_length_range();
    test_back_pressure();
    test_four_phase();
    test_zero_length();
    test_mid_packet_reset();

    $display("error counts: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
logic/stream_fifo.sv
logic/stream_pkg.sv
logic/stream_source.sv
logic/stream_checker.sv
logic/stream_loop_top.sv
sim/stream_loop_tb.sv
